// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu
  import rv_isa_pkg::*, rv_ctrl_pkg::*;
(
  input  logic [alu_op_width-1:0] op,
  input  logic [xlen-1:0]         a,
  input  logic [xlen-1:0]         b,
  output logic [xlen-1:0]         result
);

  logic [4:0] shamt;

  // only the low five bits count for rv32 shifts
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $signed(a) >>> shamt;
      alu_slt: begin
        result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      end
      alu_sltu: begin
        result = {{(xlen-1){1'b0}}, a < b};
      end
      alu_xor:    result = a ^ b;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

endmodule

// ==== design/insn_decoder.sv ====
`timescale 1ns/1ps

module insn_decoder
  import rv_isa_pkg::*, rv_ctrl_pkg::*;
(
  input  rv_insn_t                  insn,
  output logic [reg_addr_width-1:0] rs1_addr,
  output logic [reg_addr_width-1:0] rs2_addr,
  output logic [reg_addr_width-1:0] rd_addr,
  output logic [xlen-1:0]           imm,
  output logic [alu_op_width-1:0]   alu_op,
  output logic                      alu_src_imm,
  output logic                      wb_pc_rel,
  output logic                      reg_we,
  output logic                      is_branch,
  output logic                      is_store,
  output logic                      halt,
  output logic [2:0]                branch_cond
);

  logic writes;
  logic f7_zero;
  logic f7_is_alt;

  // funct3 picks the operation, alt only splits add/sub and srl/sra
  function automatic logic [alu_op_width-1:0] f3_to_alu(input logic [2:0] f3,
                                                        input logic alt);
    case (f3)
      f3_add:  return alt ? alu_sub : alu_add;
      f3_sll:  return alu_sll;
      f3_slt:  return alu_slt;
      f3_sltu: return alu_sltu;
      f3_xor:  return alu_xor;
      f3_sr:   return alt ? alu_sra : alu_srl;
      f3_or:   return alu_or;
      default: return alu_and;
    endcase
  endfunction

  // register fields sit in the same bits for every format
  assign rs1_addr    = insn.r.rs1;
  assign rs2_addr    = insn.r.rs2;
  assign rd_addr     = insn.r.rd;
  assign branch_cond = insn.b.funct3;

  assign f7_zero   = insn.r.funct7 == 7'd0;
  assign f7_is_alt = insn.r.funct7 == f7_alt;

  // x0 is never written
  assign reg_we = writes && (insn.r.rd != '0);

  always_comb begin
    imm         = '0;
    alu_op      = alu_add;
    alu_src_imm = 1'b0;
    wb_pc_rel   = 1'b0;
    writes      = 1'b0;
    is_branch   = 1'b0;
    is_store    = 1'b0;
    halt        = 1'b0;
    case (insn.r.opcode)
      op_lui: begin
        imm         = {insn.u.imm, 12'd0};
        alu_op      = alu_pass_b;
        alu_src_imm = 1'b1;
        writes      = 1'b1;
      end
      op_auipc: begin
        imm       = {insn.u.imm, 12'd0};
        wb_pc_rel = 1'b1;
        writes    = 1'b1;
      end
      op_reg_imm: begin
        imm         = {{20{insn.i.imm[11]}}, insn.i.imm};
        alu_src_imm = 1'b1;
        // shift immediates carry a funct7 in their upper bits
        alu_op = f3_to_alu(insn.i.funct3, f7_is_alt && insn.i.funct3 == f3_sr);
        if (insn.i.funct3 == f3_sll) begin
          writes = f7_zero;
        end else if (insn.i.funct3 == f3_sr) begin
          writes = f7_zero || f7_is_alt;
        end else begin
          writes = 1'b1;
        end
      end
      op_reg_reg: begin
        alu_op = f3_to_alu(insn.r.funct3, f7_is_alt);
        writes = f7_zero ||
                 (f7_is_alt && (insn.r.funct3 == f3_add || insn.r.funct3 == f3_sr));
      end
      op_branch: begin
        imm = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
               insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
        is_branch = insn.b.funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
      end
      op_store: begin
        // address is rs1 + offset through the alu
        if (insn.s.funct3 == f3_sw) begin
          imm         = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
          alu_src_imm = 1'b1;
          is_store    = 1'b1;
        end
      end
      op_environ: begin
        // ecall only, every bit above the opcode is zero
        halt = (insn.u.imm == '0) && (insn.u.rd == '0);
      end
      default: begin
        // anything else falls through as a no-op
      end
    endcase
  end

endmodule

// ==== design/pc_sequencer.sv ====
`timescale 1ns/1ps

module pc_sequencer
  import rv_isa_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            is_branch,
  input  logic            halt,
  input  logic [2:0]      branch_cond,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  logic [xlen-1:0] imm,
  output logic [xlen-1:0] pc
);

  logic            cond_met;
  logic            taken;
  logic [xlen-1:0] pc_next;

  // compare the register values, not the indices
  always_comb begin
    case (branch_cond)
      f3_beq:  cond_met = rs1_data == rs2_data;
      f3_bne:  cond_met = rs1_data != rs2_data;
      f3_blt:  cond_met = $signed(rs1_data) < $signed(rs2_data);
      f3_bge:  cond_met = $signed(rs1_data) >= $signed(rs2_data);
      f3_bltu: cond_met = rs1_data < rs2_data;
      f3_bgeu: cond_met = rs1_data >= rs2_data;
      default: cond_met = 1'b0;
    endcase
  end

  assign taken = is_branch && cond_met;

  // halt freezes the pc so the ecall stays in view
  assign pc_next = halt ? pc : (taken ? pc + imm : pc + xlen'(4));

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
  import rv_isa_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      we,
  input  logic [reg_addr_width-1:0] rd_addr,
  input  logic [reg_addr_width-1:0] rs1_addr,
  input  logic [reg_addr_width-1:0] rs2_addr,
  input  logic [xlen-1:0]           rd_data,
  output logic [xlen-1:0]           rs1_data,
  output logic [xlen-1:0]           rs2_data
);

  logic [xlen-1:0] regs [2**reg_addr_width];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // asynchronous reads, x0 forced to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps

module rv_core
  import rv_isa_pkg::*, rv_ctrl_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  logic [xlen-1:0] insn,
  output logic [xlen-1:0] pc,
  output logic [xlen-1:0] dmem_addr,
  output logic [xlen-1:0] dmem_wdata,
  output logic            dmem_we,
  output logic            halt
);

  logic [reg_addr_width-1:0] rs1_addr;
  logic [reg_addr_width-1:0] rs2_addr;
  logic [reg_addr_width-1:0] rd_addr;
  logic [xlen-1:0]           imm;
  logic [alu_op_width-1:0]   alu_op;
  logic                      alu_src_imm;
  logic                      wb_pc_rel;
  logic                      reg_we;
  logic                      is_branch;
  logic                      is_store;
  logic [2:0]                branch_cond;
  logic [xlen-1:0]           rs1_data;
  logic [xlen-1:0]           rs2_data;
  logic [xlen-1:0]           alu_b;
  logic [xlen-1:0]           alu_result;
  logic [xlen-1:0]           rd_data;

  insn_decoder insn_decoder_inst (
    .insn(insn), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
    .imm(imm), .alu_op(alu_op), .alu_src_imm(alu_src_imm), .wb_pc_rel(wb_pc_rel),
    .reg_we(reg_we), .is_branch(is_branch), .is_store(is_store), .halt(halt),
    .branch_cond(branch_cond)
  );

  // no register writes once halted
  reg_file reg_file_inst (
    .clk(clk), .rst(rst), .we(reg_we && !halt), .rd_addr(rd_addr),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_data(rd_data),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign alu_b = alu_src_imm ? imm : rs2_data;

  alu alu_inst (.op(alu_op), .a(rs1_data), .b(alu_b), .result(alu_result));

  pc_sequencer #(.reset_pc(reset_pc)) pc_sequencer_inst (
    .clk(clk), .rst(rst), .is_branch(is_branch), .halt(halt),
    .branch_cond(branch_cond), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .imm(imm), .pc(pc)
  );

  // auipc adds the upper immediate to the current pc
  assign rd_data = wb_pc_rel ? pc + imm : alu_result;

  // store port, valid in the cycle of the sw
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = is_store;

endmodule

// ==== design/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

  // width of the alu operation select
  localparam int alu_op_width = 4;

  // arithmetic
  localparam logic [alu_op_width-1:0] alu_add  = 4'd0;
  localparam logic [alu_op_width-1:0] alu_sub  = 4'd1;

  // shifts, amount taken from the low five bits of b
  localparam logic [alu_op_width-1:0] alu_sll  = 4'd2;
  localparam logic [alu_op_width-1:0] alu_srl  = 4'd3;
  localparam logic [alu_op_width-1:0] alu_sra  = 4'd4;

  // compares, result is 0 or 1
  localparam logic [alu_op_width-1:0] alu_slt  = 4'd5;
  localparam logic [alu_op_width-1:0] alu_sltu = 4'd6;

  // bitwise logic
  localparam logic [alu_op_width-1:0] alu_xor  = 4'd7;
  localparam logic [alu_op_width-1:0] alu_or   = 4'd8;
  localparam logic [alu_op_width-1:0] alu_and  = 4'd9;

  // b straight through, used by lui
  localparam logic [alu_op_width-1:0] alu_pass_b = 4'd10;

endpackage

// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // base integer width and register index width
  localparam int xlen = 32;
  localparam int reg_addr_width = 5;

  // major opcodes of the kept instructions
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_auipc   = 7'b0010111;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_environ = 7'b1110011;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // word store is the only store width kept
  localparam logic [2:0] f3_sw = 3'b010;

  // alu functions, shared by the reg-imm and reg-reg groups
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // selects sub and sra
  localparam logic [6:0] f7_alt = 7'b0100000;

  // one fetched word, seen through each instruction format
  typedef union packed {
    struct packed {logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
                   logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;} r;
    struct packed {logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
                   logic [4:0] rd; logic [6:0] opcode;} i;
    struct packed {logic [6:0] imm_hi; logic [4:0] rs2; logic [4:0] rs1;
                   logic [2:0] funct3; logic [4:0] imm_lo; logic [6:0] opcode;} s;
    struct packed {logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
                   logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11;
                   logic [6:0] opcode;} b;
    struct packed {logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;} u;
  } rv_insn_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the core with its testbench and run it under verilator
cd "$(dirname "$0")" || exit 1

out="$(verilator --binary --timing --assert -j 0 --top-module rv_core_tb \
  -f rv_core.f -o rv_core_sim 2>&1 && ./obj_dir/rv_core_sim 2>&1)"

printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'STATUS: PASS' && exit 0 || exit 1

// ==== rv_core.f ====
+incdir+tb
design/rv_isa_pkg.sv
design/rv_ctrl_pkg.sv
design/insn_decoder.sv
design/reg_file.sv
design/alu.sv
design/pc_sequencer.sv
design/rv_core.sv
tb/rv_core_tb.sv

// ==== tb/rv_insn_enc.svh ====
`ifndef RV_INSN_ENC_SVH
`define RV_INSN_ENC_SVH

// instruction word assembly, one function per format
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, op_reg_reg};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, op_reg_imm};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, f3_sw, imm[4:0], op_store};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] sext12(input logic [11:0] imm);
  return {{20{imm[11]}}, imm};
endfunction

// integer results as the isa defines them
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'd0, $signed(a) < $signed(b)};
    3'd3: return {31'd0, a < b};
    3'd4: return a ^ b;
    3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    default: return a >= b;
  endcase
endfunction

`endif

// ==== tb/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb
  import rv_isa_pkg::*;
;

  `include "rv_insn_enc.svh"

  localparam logic [31:0] reset_pc = '0;

  logic clk;
  logic rst;
  logic [31:0] insn;
  logic [31:0] pc;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic dmem_we;
  logic halt;

  // program image and what each executed word must produce
  logic [31:0] imem [256];
  bit visited [256];
  logic exp_we [256];
  logic exp_halt [256];
  logic [31:0] exp_addr [256];
  logic [31:0] exp_wdata [256];
  logic [31:0] exp_next [256];

  logic [31:0] mregs [32];
  logic [31:0] bpc;
  integer seed;
  int errors;
  int cyc = 0;
  bit built;
  logic [7:0] idx;
  logic chk = 1'b0;
  logic [31:0] expect_pc = '0;

  rv_core rv_core_inst (
    .clk(clk), .rst(rst), .insn(insn), .pc(pc), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_we(dmem_we), .halt(halt)
  );

  assign idx = pc[9:2];

  always #20 clk = ~clk;

  // fetch returns the word at pc shortly after each edge
  always @(posedge clk) begin
    #1;
    insn = imem[pc[9:2]];
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    chk <= !rst;
    expect_pc <= exp_next[idx];
  end

  task automatic wb(input logic [4:0] rd, input logic [31:0] val);
    if (rd != 5'd0) begin
      mregs[rd] = val;
    end
  endtask

  task automatic emit(input logic [31:0] word, input logic we, input logic [31:0] addr,
                      input logic [31:0] wdata, input logic hlt, input logic [31:0] nxt);
    imem[bpc[9:2]] = word;
    visited[bpc[9:2]] = 1'b1;
    exp_we[bpc[9:2]] = we;
    exp_addr[bpc[9:2]] = addr;
    exp_wdata[bpc[9:2]] = wdata;
    exp_halt[bpc[9:2]] = hlt;
    exp_next[bpc[9:2]] = nxt;
    bpc = nxt;
  endtask

  // lui then addi with the upper part rounded for the signed low half
  task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [19:0] hi;
    logic [11:0] lo;
    lo = value[11:0];
    hi = value[31:12] + {19'd0, lo[11]};
    emit(enc_u(hi, rd, op_lui), 1'b0, '0, '0, 1'b0, bpc + 32'd4);
    wb(rd, {hi, 12'd0});
    emit(enc_i(lo, rd, f3_add, rd), 1'b0, '0, '0, 1'b0, bpc + 32'd4);
    wb(rd, mregs[rd] + sext12(lo));
  endtask

  // stores use x1 as the base register
  task automatic store_reg(input logic [4:0] rs);
    logic [31:0] r;
    r = $random(seed);
    emit(enc_s(r[11:0], rs, 5'd1), 1'b1, mregs[1] + sext12(r[11:0]), mregs[rs], 1'b0,
         bpc + 32'd4);
  endtask

  task automatic alu_imm(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] res;
    res = alu_ref(f3, alt, mregs[rs1], sext12(imm));
    emit(enc_i(imm, rs1, f3, rd), 1'b0, '0, '0, 1'b0, bpc + 32'd4);
    wb(rd, res);
    store_reg(rd);
  endtask

  task automatic alu_reg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] res;
    res = alu_ref(f3, alt, mregs[rs1], mregs[rs2]);
    emit(enc_r(alt ? f7_alt : 7'd0, rs2, rs1, f3, rd), 1'b0, '0, '0, 1'b0, bpc + 32'd4);
    wb(rd, res);
    store_reg(rd);
  endtask

  // taken branches jump over a word that would corrupt x1
  task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] skip;
    skip = bpc + 32'd4;
    if (branch_ref(f3, mregs[rs1], mregs[rs2])) begin
      imem[skip[9:2]] = enc_i(12'd1, 5'd1, f3_add, 5'd1);
      emit(enc_b(13'd8, rs2, rs1, f3), 1'b0, '0, '0, 1'b0, bpc + 32'd8);
    end else begin
      emit(enc_b(13'd8, rs2, rs1, f3), 1'b0, '0, '0, 1'b0, bpc + 32'd4);
    end
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] auipc_res;
    bpc = reset_pc;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    r = $random(seed);
    set_reg(5'd1, r & 32'h7fffffff);
    r = $random(seed);
    set_reg(5'd2, r);
    r = $random(seed);
    set_reg(5'd3, r | 32'h80000000);
    // register-immediate group
    r = $random(seed);
    alu_imm(f3_add, 1'b0, 5'd4, 5'd1, r[11:0]);
    alu_imm(f3_slt, 1'b0, 5'd4, 5'd3, r[11:0]);
    alu_imm(f3_sltu, 1'b0, 5'd4, 5'd3, 12'hfff);
    alu_imm(f3_xor, 1'b0, 5'd4, 5'd2, r[23:12]);
    alu_imm(f3_or, 1'b0, 5'd4, 5'd2, r[11:0]);
    alu_imm(f3_and, 1'b0, 5'd4, 5'd2, r[23:12]);
    alu_imm(f3_sll, 1'b0, 5'd4, 5'd2, {7'd0, r[28:24]});
    alu_imm(f3_sr, 1'b0, 5'd4, 5'd3, {7'd0, r[28:24]});
    alu_imm(f3_sr, 1'b1, 5'd4, 5'd3, {f7_alt, r[28:24]});
    r = $random(seed);
    emit(enc_u(r[19:0], 5'd5, op_lui), 1'b0, '0, '0, 1'b0, bpc + 32'd4);
    wb(5'd5, {r[19:0], 12'd0});
    store_reg(5'd5);
    auipc_res = bpc + {r[31:12], 12'd0};
    emit(enc_u(r[31:12], 5'd6, op_auipc), 1'b0, '0, '0, 1'b0, bpc + 32'd4);
    wb(5'd6, auipc_res);
    store_reg(5'd6);
    // register-register group where x3 is negative
    alu_reg(f3_add, 1'b0, 5'd7, 5'd1, 5'd2);
    alu_reg(f3_add, 1'b1, 5'd7, 5'd1, 5'd3);
    alu_reg(f3_sll, 1'b0, 5'd7, 5'd2, 5'd1);
    alu_reg(f3_slt, 1'b0, 5'd7, 5'd3, 5'd1);
    alu_reg(f3_sltu, 1'b0, 5'd7, 5'd3, 5'd1);
    alu_reg(f3_xor, 1'b0, 5'd7, 5'd1, 5'd2);
    alu_reg(f3_sr, 1'b0, 5'd7, 5'd3, 5'd2);
    alu_reg(f3_sr, 1'b1, 5'd7, 5'd3, 5'd2);
    alu_reg(f3_or, 1'b0, 5'd7, 5'd1, 5'd3);
    alu_reg(f3_and, 1'b0, 5'd7, 5'd2, 5'd3);
    // x0 must ignore writes
    alu_imm(f3_add, 1'b0, 5'd0, 5'd1, 12'd5);
    alu_reg(f3_add, 1'b0, 5'd0, 5'd1, 5'd2);
    branch(f3_beq, 5'd1, 5'd3);
    branch(f3_beq, 5'd1, 5'd1);
    branch(f3_bne, 5'd1, 5'd3);
    branch(f3_bne, 5'd1, 5'd1);
    branch(f3_blt, 5'd1, 5'd3);
    branch(f3_blt, 5'd3, 5'd1);
    branch(f3_bge, 5'd1, 5'd3);
    branch(f3_bge, 5'd3, 5'd1);
    branch(f3_bltu, 5'd1, 5'd3);
    branch(f3_bltu, 5'd3, 5'd1);
    branch(f3_bgeu, 5'd1, 5'd3);
    branch(f3_bgeu, 5'd3, 5'd1);
    store_reg(5'd1);
    // ecall holds the pc where it is
    emit(32'h00000073, 1'b0, '0, '0, 1'b1, bpc);
  endtask

  a_reset_pc: assert property (@(posedge clk) (rst && cyc != 0) |-> pc == reset_pc)
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: pc expected %h got %h", $time, reset_pc, $sampled(pc));
    end

  a_reset_we: assert property (@(posedge clk) (rst && cyc != 0) |-> !dmem_we)
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: dmem_we expected 0 got %b", $time, $sampled(dmem_we));
    end

  a_reset_halt: assert property (@(posedge clk) (rst && cyc != 0) |-> !halt)
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: halt expected 0 got %b", $time, $sampled(halt));
    end

  a_visit: assert property (@(posedge clk) !rst |-> (pc[31:10] == '0 && visited[idx]))
    else begin
      errors = errors + 1;
      $display("pc %h at %0t is not on the executed program path", $sampled(pc), $time);
    end

  a_we: assert property (@(posedge clk) !rst |-> dmem_we == exp_we[idx])
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: dmem_we expected %b got %b", $time,
               exp_we[$sampled(idx)], $sampled(dmem_we));
    end

  a_wdata: assert property (@(posedge clk) (!rst && exp_we[idx]) |->
                            dmem_wdata == exp_wdata[idx])
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: dmem_wdata expected %h got %h", $time,
               exp_wdata[$sampled(idx)], $sampled(dmem_wdata));
    end

  a_addr: assert property (@(posedge clk) (!rst && exp_we[idx]) |->
                           dmem_addr == exp_addr[idx])
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: dmem_addr expected %h got %h", $time,
               exp_addr[$sampled(idx)], $sampled(dmem_addr));
    end

  a_halt: assert property (@(posedge clk) !rst |-> halt == exp_halt[idx])
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: halt expected %b got %b", $time,
               exp_halt[$sampled(idx)], $sampled(halt));
    end

  a_next_pc: assert property (@(posedge clk) chk |-> pc == expect_pc)
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: pc expected %h got %h", $time,
               $sampled(expect_pc), $sampled(pc));
    end

  initial begin
    longint limit;
    wait (built);
    limit = (longint'(bpc[31:2]) + 1 + 8) * 2 * 40;
    #(limit);
    $display("timeout: core did not halt within %0d ns", limit);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    insn = '0;
    errors = 0;
    seed = 32'hceaa23e4;
    build_program();
    built = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    while (halt !== 1'b1) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    #1;
    $display("run complete, errors: %0d", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
